// File: verilog/dqmPkg.sv
package dqmPkg;

    // channel and datapath sizes.
    localparam int numSrc  = 4;
    localparam int sampleW = 16;
    localparam int mseW    = 32;

    // register map, byte addresses.
    localparam logic [12:0] addrMseControl  = 13'h0000;
    localparam logic [12:0] addrLog10Mse    = 13'h0004;
    localparam logic [12:0] addrClksPerBit  = 13'h0008;
    localparam logic [12:0] addrPayloadSize = 13'h000C;
    localparam logic [12:0] addrSrcSelect   = 13'h0010;

    // log2 to log10 scaling, 1233 / 4096 is about log10(2).
    localparam int log10Scale = 1233;
    localparam int log10Shift = 12;

    typedef struct packed {
        logic [12:0] addr;
        logic [31:0] dataIn;
        logic        cs;
        logic [3:0]  byteWr;
    } dqmBusReq;

    typedef struct packed {
        logic [15:0]        mseMean;
        logic [15:0]        mseAvgLength;
        logic signed [15:0] log10MseOffset;
        logic [13:0]        payloadSize;
        logic [15:0]        clksPerBit;
        logic [3:0]         sourceSelect;
    } dqmConfig;

    typedef struct packed {
        logic [15:0] mseAvgLength;
        logic [15:0] mseMean;
    } mseCtlWord;

    typedef struct packed {
        logic signed [15:0] log10MseOffset;
        logic signed [15:0] log10Mse;
    } logWord;

    // shared by the clksPerBit and payloadSize addresses.
    typedef struct packed {
        logic [1:0]  zero;
        logic [13:0] payloadSize;
        logic [15:0] clksPerBit;
    } rateWord;

    typedef union packed {
        mseCtlWord mseCtl;
        logWord    logView;
        rateWord   rateView;
    } dqmRegWord;

    // one mseW word per channel.
    typedef logic [numSrc-1:0][mseW-1:0] mseArray;

endpackage

// File: verilog/dqmRegs.sv
`timescale 1ns/1ps

module dqmRegs (
    input  logic               busClk,
    input  logic               arstN,
    input  dqmPkg::dqmBusReq   busReq,
    input  logic signed [15:0] dqmValue,
    input  logic               dqmReady,
    output logic [31:0]        dataOut,
    output dqmPkg::dqmConfig   cfg
);
    import dqmPkg::*;

    dqmRegWord          wrWord;
    dqmRegWord          rdWord;
    logic signed [15:0] log10Mse;

    assign wrWord = busReq.dataIn;

    // byte lane writes.
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            cfg <= '0;
        end else if (busReq.cs) begin
            if (busReq.byteWr[0]) begin
                case (busReq.addr)
                    addrMseControl: cfg.mseMean[7:0] <= wrWord.mseCtl.mseMean[7:0];
                    addrClksPerBit: cfg.clksPerBit[7:0] <= wrWord.rateView.clksPerBit[7:0];
                    addrSrcSelect:  cfg.sourceSelect <= busReq.dataIn[3:0];
                    default: ;
                endcase
            end
            if (busReq.byteWr[1]) begin
                case (busReq.addr)
                    addrMseControl: cfg.mseMean[15:8] <= wrWord.mseCtl.mseMean[15:8];
                    addrClksPerBit: cfg.clksPerBit[15:8] <= wrWord.rateView.clksPerBit[15:8];
                    default: ;
                endcase
            end
            if (busReq.byteWr[2]) begin
                case (busReq.addr)
                    addrLog10Mse: begin
                        cfg.log10MseOffset[7:0] <= wrWord.logView.log10MseOffset[7:0];
                    end
                    addrMseControl: begin
                        cfg.mseAvgLength[7:0] <= wrWord.mseCtl.mseAvgLength[7:0];
                    end
                    addrPayloadSize: begin
                        cfg.payloadSize[7:0] <= wrWord.rateView.payloadSize[7:0];
                    end
                    default: ;
                endcase
            end
            if (busReq.byteWr[3]) begin
                case (busReq.addr)
                    addrLog10Mse: begin
                        cfg.log10MseOffset[15:8] <= wrWord.logView.log10MseOffset[15:8];
                    end
                    addrMseControl: begin
                        cfg.mseAvgLength[15:8] <= wrWord.mseCtl.mseAvgLength[15:8];
                    end
                    addrPayloadSize: begin
                        cfg.payloadSize[13:8] <= wrWord.rateView.payloadSize[13:8];
                    end
                    default: ;
                endcase
            end
        end
    end

    // last published quality value.
    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            log10Mse <= '0;
        end else if (dqmReady) begin
            log10Mse <= dqmValue;
        end
    end

    always_comb begin
        rdWord = '0;
        case (busReq.addr)
            addrMseControl: begin
                rdWord.mseCtl.mseAvgLength = cfg.mseAvgLength;
                rdWord.mseCtl.mseMean      = cfg.mseMean;
            end
            addrLog10Mse: begin
                rdWord.logView.log10MseOffset = cfg.log10MseOffset;
                rdWord.logView.log10Mse       = log10Mse;
            end
            addrClksPerBit, addrPayloadSize: begin
                rdWord.rateView.payloadSize = cfg.payloadSize;
                rdWord.rateView.clksPerBit  = cfg.clksPerBit;
            end
            addrSrcSelect: rdWord = {28'd0, cfg.sourceSelect};
            default: ;
        endcase
    end

    assign dataOut = busReq.cs ? rdWord : 32'd0;

endmodule

// File: verilog/bitSampler.sv
`timescale 1ns/1ps

module bitSampler (
    input  logic                                          busClk,
    input  logic                                          arstN,
    input  logic [15:0]                                   clksPerBit,
    input  logic [15:0]                                   mseMean,
    input  logic [dqmPkg::numSrc-1:0][dqmPkg::sampleW-1:0] sampleIn,
    output dqmPkg::mseArray                               sqErr,
    output logic                                          bitStrb
);
    import dqmPkg::*;

    logic [15:0] bitCnt;
    logic [15:0] lastCnt;
    logic [15:0] prevClksPerBit;
    logic        rateChange;
    logic        bitEnd;
    mseArray     sqErrNext;

    // |sample| - mean as a wrapped 17 bit value, squared and saturated.
    function automatic logic [mseW-1:0] squareErr(input logic [sampleW-1:0] sample,
                                                  input logic [15:0] mean);
        logic signed [sampleW:0]     sampleExt;
        logic [sampleW:0]            absSample;
        logic signed [sampleW:0]     err;
        logic signed [2*sampleW+1:0] square;
        sampleExt = {sample[sampleW-1], sample};
        absSample = sampleExt[sampleW] ? -sampleExt : sampleExt;
        err       = $signed(absSample - {1'b0, mean});
        square    = err * err;
        return (|square[2*sampleW+1:mseW]) ? '1 : square[mseW-1:0];
    endfunction

    always_comb begin
        for (int ch = 0; ch < numSrc; ch++) begin
            sqErrNext[ch] = squareErr(sampleIn[ch], mseMean);
        end
    end

    // zero counts as one clock per bit.
    assign lastCnt    = (clksPerBit == 16'd0) ? 16'd0 : clksPerBit - 16'd1;
    assign rateChange = (clksPerBit != prevClksPerBit);
    assign bitEnd     = !rateChange && (bitCnt >= lastCnt);

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            bitCnt         <= '0;
            prevClksPerBit <= '0;
            bitStrb        <= 1'b0;
        end else begin
            prevClksPerBit <= clksPerBit;
            bitStrb        <= bitEnd;
            if (rateChange || bitEnd) begin
                bitCnt <= '0;
            end else begin
                bitCnt <= bitCnt + 16'd1;
            end
        end
    end

    always_ff @(posedge busClk) begin
        if (bitEnd) begin
            sqErr <= sqErrNext;
        end
    end

endmodule

// File: verilog/mseAverager.sv
`timescale 1ns/1ps

module mseAverager (
    input  logic                    busClk,
    input  logic                    arstN,
    input  logic [3:0]              avgShift,
    input  logic                    bitStrb,
    input  logic [dqmPkg::mseW-1:0] sqErr,
    output logic [dqmPkg::mseW-1:0] mseEst,
    output logic                    mseValid
);
    import dqmPkg::*;

    logic signed [mseW:0] delta;
    logic signed [mseW:0] step;
    logic [mseW-1:0]      estNext;

    // est += (x - est) >>> shift.
    assign delta = $signed({1'b0, sqErr}) - $signed({1'b0, mseEst});
    assign step  = delta >>> avgShift;

    // the true sum lies between est and x, so the low bits are exact.
    assign estNext = mseEst + step[mseW-1:0];

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            mseEst   <= '0;
            mseValid <= 1'b0;
        end else begin
            mseValid <= bitStrb;
            if (bitStrb) begin
                mseEst <= estNext;
            end
        end
    end

endmodule

// File: verilog/mseLogConvert.sv
`timescale 1ns/1ps

module mseLogConvert (
    input  logic               busClk,
    input  logic               arstN,
    input  dqmPkg::mseArray    mseEst,
    input  logic               mseValid,
    input  logic [3:0]         sourceSelect,
    input  logic signed [15:0] log10MseOffset,
    input  logic [13:0]        payloadSize,
    output logic signed [15:0] dqmValue,
    output logic               dqmReady
);
    import dqmPkg::*;

    localparam int idxW = $clog2(mseW);
    localparam int selW = $clog2(numSrc);

    logic [mseW-1:0]    selEst;
    logic [idxW-1:0]    msbIdx;
    logic [mseW+7:0]    fracExt;
    logic [15:0]        log2Val;
    logic [31:0]        log10Prod;
    logic signed [15:0] logResult;
    logic [13:0]        bitCnt;
    logic               payloadEnd;

    // out of range selects read as zero.
    assign selEst = (sourceSelect < numSrc) ? mseEst[sourceSelect[selW-1:0]] : '0;

    // leading one position.
    always_comb begin
        msbIdx = '0;
        for (int i = 0; i < mseW; i++) begin
            if (selEst[i]) begin
                msbIdx = idxW'(i);
            end
        end
    end

    // eight bits below the leading one, zero filled under bit 0.
    assign fracExt = {selEst, 8'd0} >> msbIdx;

    // Q8.8 log2.
    assign log2Val = {(8 - idxW)'(0), msbIdx, fracExt[7:0]};

    assign log10Prod = log2Val * log10Scale;
    assign logResult = 16'(log10Prod >> log10Shift) + log10MseOffset;

    // sizes 0 and 1 both close the payload on every bit.
    assign payloadEnd = (bitCnt + 14'd1) >= payloadSize;

    always_ff @(posedge busClk or negedge arstN) begin
        if (!arstN) begin
            bitCnt   <= '0;
            dqmReady <= 1'b0;
            dqmValue <= '0;
        end else begin
            dqmReady <= mseValid && payloadEnd;
            if (mseValid) begin
                if (payloadEnd) begin
                    bitCnt   <= '0;
                    dqmValue <= logResult;
                end else begin
                    bitCnt <= bitCnt + 14'd1;
                end
            end
        end
    end

endmodule

// File: verilog/dqmTop.sv
`timescale 1ns/1ps

module dqmTop (
    input  logic                                          busClk,
    input  logic                                          arstN,
    input  dqmPkg::dqmBusReq                              busReq,
    output logic [31:0]                                   dataOut,
    input  logic [dqmPkg::numSrc-1:0][dqmPkg::sampleW-1:0] sampleIn,
    output logic signed [15:0]                            dqmValue,
    output logic                                          dqmReady
);
    import dqmPkg::*;

    dqmConfig          cfg;
    mseArray           sqErr;
    mseArray           mseEst;
    logic              bitStrb;
    logic [numSrc-1:0] validVec;
    logic              mseValid;

    dqmRegs iRegs (
        .busClk   (busClk),
        .arstN    (arstN),
        .busReq   (busReq),
        .dqmValue (dqmValue),
        .dqmReady (dqmReady),
        .dataOut  (dataOut),
        .cfg      (cfg)
    );

    bitSampler iSampler (
        .busClk     (busClk),
        .arstN      (arstN),
        .clksPerBit (cfg.clksPerBit),
        .mseMean    (cfg.mseMean),
        .sampleIn   (sampleIn),
        .sqErr      (sqErr),
        .bitStrb    (bitStrb)
    );

    for (genvar ch = 0; ch < numSrc; ch++) begin : gAvg
        mseAverager iAvg (
            .busClk   (busClk),
            .arstN    (arstN),
            .avgShift (cfg.mseAvgLength[3:0]),
            .bitStrb  (bitStrb),
            .sqErr    (sqErr[ch]),
            .mseEst   (mseEst[ch]),
            .mseValid (validVec[ch])
        );
    end

    // all averagers step together.
    assign mseValid = validVec[0];

    mseLogConvert iConvert (
        .busClk         (busClk),
        .arstN          (arstN),
        .mseEst         (mseEst),
        .mseValid       (mseValid),
        .sourceSelect   (cfg.sourceSelect),
        .log10MseOffset (cfg.log10MseOffset),
        .payloadSize    (cfg.payloadSize),
        .dqmValue       (dqmValue),
        .dqmReady       (dqmReady)
    );

endmodule

// File: verif/dqmTb.sv
`timescale 1ns/1ps

module dqmTb;
    import dqmPkg::*;

    localparam int maxCycles = 20000;
    localparam logic [15:0] meanVal = 16'd1000;

    logic                             busClk;
    logic                             arstN;
    dqmBusReq                         busReq;
    logic [31:0]                      dataOut;
    logic [numSrc-1:0][sampleW-1:0]   sampleIn;
    logic signed [15:0]               dqmValue;
    logic                             dqmReady;

    int                 cycle;
    int                 seed;
    int                 readyCycle;
    int                 lastReady;
    logic [31:0]        modelEst [numSrc];
    logic [15:0]        curMean;
    logic [3:0]         curShift;
    logic signed [15:0] curOffset;

    dqmTop i_dut (
        .busClk   (busClk),
        .arstN    (arstN),
        .busReq   (busReq),
        .dataOut  (dataOut),
        .sampleIn (sampleIn),
        .dqmValue (dqmValue),
        .dqmReady (dqmReady)
    );

    initial busClk = 1'b0;
    always #5 busClk = ~busClk;

    // watchdog.
    always @(posedge busClk) begin
        cycle <= cycle + 1;
        if (cycle >= maxCycles) begin
            $display("timeout, no progress within %0d cycles", maxCycles);
            $display("TB FAILED");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("ERROR %s expected %h actual %h", name, exp, act);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic busWrite(input logic [12:0] addr, input logic [31:0] data,
                            input logic [3:0] lanes);
        @(posedge busClk);
        #1;
        busReq.addr   = addr;
        busReq.dataIn = data;
        busReq.byteWr = lanes;
        busReq.cs     = 1'b1;
        @(posedge busClk);
        #1;
        busReq.cs     = 1'b0;
        busReq.byteWr = 4'h0;
    endtask

    task automatic busRead(input logic [12:0] addr, input logic csVal,
                           output logic [31:0] data);
        @(posedge busClk);
        #1;
        busReq.addr   = addr;
        busReq.byteWr = 4'h0;
        busReq.cs     = csVal;
        @(negedge busClk);
        data      = dataOut;
        busReq.cs = 1'b0;
    endtask

    task automatic setSamples(input logic [numSrc-1:0][sampleW-1:0] smp);
        @(posedge busClk);
        #1;
        sampleIn = smp;
    endtask

    // samples at the falling edge, away from the register updates.
    task automatic waitReady(output logic signed [15:0] val);
        do begin
            @(negedge busClk);
        end while (!dqmReady);
        val        = dqmValue;
        lastReady  = readyCycle;
        readyCycle = cycle;
    endtask

    function automatic logic [31:0] sqModel(input logic signed [15:0] s, input logic [15:0] m);
        longint mag;
        longint err;
        longint sq;
        mag = (s < 0) ? -longint'(s) : longint'(s);
        err = mag - longint'(m);
        sq  = err * err;
        return (sq > 64'hFFFF_FFFF) ? 32'hFFFF_FFFF : sq[31:0];
    endfunction

    function automatic logic signed [15:0] logModel(input logic [31:0] est,
                                                    input logic signed [15:0] off);
        int     idx;
        int     frac;
        longint l2;
        idx = 0;
        for (int i = 0; i < 32; i++) begin
            if (est[i]) idx = i;
        end
        if (idx >= 8) frac = (est >> (idx - 8)) & 255;
        else frac = (est << (8 - idx)) & 255;
        l2 = idx * 256 + frac;
        return 16'((l2 * 1233) >>> 12) + off;
    endfunction

    // one averager step per bit on every channel.
    task automatic stepModel(input int bits);
        longint d;
        for (int b = 0; b < bits; b++) begin
            for (int ch = 0; ch < numSrc; ch++) begin
                d = longint'(sqModel(sampleIn[ch], curMean)) - longint'(modelEst[ch]);
                modelEst[ch] = 32'(longint'(modelEst[ch]) + (d >>> curShift));
            end
        end
    endtask

    task automatic regAccessTest();
        logic [31:0]        rd;
        logic signed [15:0] v;
        dqmRegWord          w;
        logic [12:0]        addrs [5];
        addrs = '{addrMseControl, addrLog10Mse, addrClksPerBit, addrPayloadSize, addrSrcSelect};
        foreach (addrs[i]) begin
            busRead(addrs[i], 1'b1, rd);
            check("regs reset", 32'd0, rd);
        end
        busWrite(addrMseControl, 32'h1234_5678, 4'b0101);
        busRead(addrMseControl, 1'b1, rd);
        check("regs lanes 0 2", 32'h0034_0078, rd);
        busWrite(addrMseControl, 32'hAABB_CCDD, 4'b1010);
        busRead(addrMseControl, 1'b1, rd);
        w = rd;
        check("regs avgLength", 32'hAA34, w.mseCtl.mseAvgLength);
        check("regs mean", 32'hCC78, w.mseCtl.mseMean);
        busWrite(addrMseControl, 32'd0, 4'hF);
        // let the zero mean reach the published value.
        repeat (3) waitReady(v);
        // the log10Mse half is read only.
        busWrite(addrLog10Mse, 32'hFFFF_FFFF, 4'b0011);
        busRead(addrLog10Mse, 1'b1, rd);
        check("regs read only", 32'd0, rd);
        busWrite(addrClksPerBit, 32'hFFFF_0005, 4'hF);
        busWrite(addrPayloadSize, 32'hFFFF_FFFF, 4'hF);
        busRead(addrClksPerBit, 1'b1, rd);
        w = rd;
        check("regs rate zero", 32'd0, w.rateView.zero);
        check("regs payload", 32'h3FFF, w.rateView.payloadSize);
        check("regs clks", 32'd5, w.rateView.clksPerBit);
        busRead(addrPayloadSize, 1'b1, rd);
        check("regs shared layout", 32'h3FFF_0005, rd);
        busWrite(addrSrcSelect, 32'hFFFF_FFFF, 4'b0001);
        busRead(addrSrcSelect, 1'b1, rd);
        check("regs srcSelect", 32'hF, rd);
        busRead(addrSrcSelect, 1'b0, rd);
        check("regs cs low", 32'd0, rd);
        busWrite(addrSrcSelect, 32'd0, 4'b0001);
        busWrite(addrPayloadSize, 32'h0001_0000, 4'b1100);
    endtask

    task automatic bitRateTest();
        logic signed [15:0] v;
        int                 rates [3];
        rates = '{1, 3, 7};
        foreach (rates[i]) begin
            busWrite(addrClksPerBit, rates[i], 4'b0011);
            // pulses at the old rate drain within three cycles.
            repeat (3) @(posedge busClk);
            waitReady(v);
            for (int k = 0; k < 2; k++) begin
                waitReady(v);
                check("bit rate", rates[i], readyCycle - lastReady);
            end
        end
    endtask

    task automatic averagingTest();
        logic signed [15:0]             v;
        logic [numSrc-1:0][sampleW-1:0] smp;
        int                             tries;
        // flush the estimates with zero error and a copying averager.
        for (int ch = 0; ch < numSrc; ch++) smp[ch] = meanVal;
        setSamples(smp);
        busWrite(addrMseControl, {16'd0, meanVal}, 4'hF);
        for (int k = 0; k < 3; k++) waitReady(v);
        busWrite(addrMseControl, {16'd2, meanVal}, 4'hF);
        waitReady(v);
        waitReady(v);
        check("avg flushed", 32'd0, 32'(v));
        curMean   = meanVal;
        curShift  = 4'd2;
        curOffset = 16'sd0;
        for (int ch = 0; ch < numSrc; ch++) begin
            modelEst[ch] = 32'd0;
            smp[ch]      = 16'($random(seed));
        end
        setSamples(smp);
        tries = 0;
        do begin
            waitReady(v);
            tries++;
        end while (v == 16'sd0 && tries < 6);
        for (int k = 0; k < 10; k++) begin
            if (k > 0) waitReady(v);
            stepModel(1);
            check("averaging", logModel(modelEst[0], curOffset), 32'(v));
        end
    endtask

    task automatic offsetSelectTest();
        logic signed [15:0] v;
        int                 sels [4];
        sels = '{0, 2, 5, 1};
        curOffset = -16'sd300;
        busWrite(addrLog10Mse, {curOffset, 16'd0}, 4'b1100);
        foreach (sels[i]) begin
            if (i > 0) busWrite(addrSrcSelect, sels[i], 4'b0001);
            waitReady(v);
            stepModel(1);
            if (sels[i] < numSrc) begin
                check("offset select", logModel(modelEst[sels[i]], curOffset), 32'(v));
            end else begin
                check("offset only", 32'(curOffset), 32'(v));
            end
        end
    endtask

    task automatic payloadTest();
        logic signed [15:0] v;
        logic [31:0]        rd;
        dqmRegWord          w;
        busWrite(addrPayloadSize, {16'd6, 16'd0}, 4'b1100);
        for (int k = 0; k < 3; k++) begin
            waitReady(v);
            stepModel(6);
            check("payload value", logModel(modelEst[1], curOffset), 32'(v));
            if (k > 0) check("payload spacing", 32'd42, readyCycle - lastReady);
        end
        busRead(addrLog10Mse, 1'b1, rd);
        w = rd;
        check("payload readback", 32'(v), 32'(w.logView.log10Mse));
        check("offset readback", 32'(curOffset), 32'(w.logView.log10MseOffset));
    endtask

    initial begin
        cycle      = 0;
        seed       = 33;
        readyCycle = 0;
        lastReady  = 0;
        busReq     = '0;
        sampleIn   = '0;
        arstN      = 1'b0;
        repeat (8) @(posedge busClk);
        #1;
        arstN = 1'b1;
        regAccessTest();
        bitRateTest();
        averagingTest();
        offsetSelectTest();
        payloadTest();
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: dqmTop.f
verilog/dqmPkg.sv
verilog/dqmRegs.sv
verilog/bitSampler.sv
verilog/mseAverager.sv
verilog/mseLogConvert.sv
verilog/dqmTop.sv
verif/dqmTb.sv
